// File: include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath widths
`define INST_W      32
`define DATA_W      32
`define REG_IDX_W   5
`define NUM_REGS    32
`define ALU_OP_W    12

// bl writes its return address here
`define LINK_REG    1
// pc offset of the link value for jirl and bl
`define PC_STEP     4

// 3R and shift by immediate, matched on inst[31:15]
`define OP_ADD_W    17'h00020
`define OP_SUB_W    17'h00022
`define OP_SLT      17'h00024
`define OP_SLTU     17'h00025
`define OP_NOR      17'h00028
`define OP_AND      17'h00029
`define OP_OR       17'h0002a
`define OP_XOR      17'h0002b
`define OP_SLL_W    17'h0002e
`define OP_SRL_W    17'h0002f
`define OP_SRA_W    17'h00030
`define OP_SLLI_W   17'h00081
`define OP_SRLI_W   17'h00089
`define OP_SRAI_W   17'h00091

// 2RI12, matched on inst[31:22]
`define OP_SLTI     10'h008
`define OP_SLTIU    10'h009
`define OP_ADDI_W   10'h00a
`define OP_ANDI     10'h00d
`define OP_ORI      10'h00e
`define OP_XORI     10'h00f
`define OP_LD_W     10'h0a2
`define OP_ST_W     10'h0a6

// 1RI20, matched on inst[31:25]
`define OP_LU12I_W  7'h0a
`define OP_PCADDU12I 7'h0e

// jumps and branches, matched on inst[31:26]
`define OP_JIRL     6'h13
`define OP_B        6'h14
`define OP_BL       6'h15
`define OP_BEQ      6'h16
`define OP_BNE      6'h17
`define OP_BLT      6'h18
`define OP_BGE      6'h19
`define OP_BLTU     6'h1a
`define OP_BGEU     6'h1b

`endif

// File: hw/isa_pkg.sv
`include "decode_config.svh"

package isa_pkg;

    // one fetched instruction
    typedef logic [`INST_W-1:0] inst_t;

    // data word, also used for pc values
    typedef logic [`DATA_W-1:0] word_t;

    // architectural register number
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // one-hot alu select
    // bit order: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`ALU_OP_W-1:0] alu_op_t;

endpackage

// File: hw/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        isa_pkg::inst_t inst;
        isa_pkg::word_t pc;
    } fetch_packet_t;

    // register write, used by writeback and the bypass paths
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t dest;
        isa_pkg::word_t    data;
    } reg_write_t;

    typedef struct packed {
        reg_write_t wr;
        logic       is_load;
    } exec_bypass_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } branch_t;

    // one-hot over the control-flow instructions
    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jump_rel;
        logic jirl;
    } br_kind_t;

    typedef struct packed {
        isa_pkg::alu_op_t  alu_op;
        isa_pkg::word_t    imm;
        isa_pkg::reg_idx_t dest;
        logic              gr_we;
        logic              mem_we;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              res_from_mem;
        isa_pkg::reg_idx_t raddr1;
        isa_pkg::reg_idx_t raddr2;
        logic              reads_rj;
        logic              reads_rkd;
        br_kind_t          br_kind;
        // raw branch offset, {inst[9:0], inst[25:10]}
        logic [25:0]       offs;
    } decode_ctrl_t;

    typedef struct packed {
        isa_pkg::word_t   pc;
        isa_pkg::word_t   rj_value;
        isa_pkg::word_t   rkd_value;
        isa_pkg::word_t   imm;
        isa_pkg::reg_idx_t dest;
        logic             gr_we;
        logic             mem_we;
        isa_pkg::alu_op_t alu_op;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic             res_from_mem;
    } decode_packet_t;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module inst_decoder (
    input  isa_pkg::inst_t         inst,
    output pipe_pkg::decode_ctrl_t ctrl
);
    import isa_pkg::*;

    logic [16:0] op_31_15;
    logic [9:0]  op_31_22;
    logic [6:0]  op_31_25;
    logic [5:0]  op_31_26;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    word_t       imm;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_and, inst_or;
    logic inst_xor, inst_nor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_slti;
    logic inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic alu_rr, alu_ri, cond_br;
    logic need_ui5, need_si12, need_si20, need_ui12, src2_is_4;

    assign op_31_15 = inst[31:15];
    assign op_31_22 = inst[31:22];
    assign op_31_25 = inst[31:25];
    assign op_31_26 = inst[31:26];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];

    assign inst_add_w     = (op_31_15 == `OP_ADD_W);
    assign inst_sub_w     = (op_31_15 == `OP_SUB_W);
    assign inst_slt       = (op_31_15 == `OP_SLT);
    assign inst_sltu      = (op_31_15 == `OP_SLTU);
    assign inst_nor       = (op_31_15 == `OP_NOR);
    assign inst_and       = (op_31_15 == `OP_AND);
    assign inst_or        = (op_31_15 == `OP_OR);
    assign inst_xor       = (op_31_15 == `OP_XOR);
    assign inst_sll_w     = (op_31_15 == `OP_SLL_W);
    assign inst_srl_w     = (op_31_15 == `OP_SRL_W);
    assign inst_sra_w     = (op_31_15 == `OP_SRA_W);
    assign inst_slli_w    = (op_31_15 == `OP_SLLI_W);
    assign inst_srli_w    = (op_31_15 == `OP_SRLI_W);
    assign inst_srai_w    = (op_31_15 == `OP_SRAI_W);
    assign inst_slti      = (op_31_22 == `OP_SLTI);
    assign inst_sltiu     = (op_31_22 == `OP_SLTIU);
    assign inst_addi_w    = (op_31_22 == `OP_ADDI_W);
    assign inst_andi      = (op_31_22 == `OP_ANDI);
    assign inst_ori       = (op_31_22 == `OP_ORI);
    assign inst_xori      = (op_31_22 == `OP_XORI);
    assign inst_ld_w      = (op_31_22 == `OP_LD_W);
    assign inst_st_w      = (op_31_22 == `OP_ST_W);
    assign inst_lu12i_w   = (op_31_25 == `OP_LU12I_W);
    assign inst_pcaddu12i = (op_31_25 == `OP_PCADDU12I);
    assign inst_jirl      = (op_31_26 == `OP_JIRL);
    assign inst_b         = (op_31_26 == `OP_B);
    assign inst_bl        = (op_31_26 == `OP_BL);
    assign inst_beq       = (op_31_26 == `OP_BEQ);
    assign inst_bne       = (op_31_26 == `OP_BNE);
    assign inst_blt       = (op_31_26 == `OP_BLT);
    assign inst_bge       = (op_31_26 == `OP_BGE);
    assign inst_bltu      = (op_31_26 == `OP_BLTU);
    assign inst_bgeu      = (op_31_26 == `OP_BGEU);

    // instruction groups
    assign alu_rr  = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign alu_ri  = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                   | inst_sltiu | inst_andi | inst_ori | inst_xori;
    assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltiu | inst_ld_w | inst_st_w;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign src2_is_4 = inst_jirl | inst_bl;

    // link value rides on the immediate, so it wins over everything else
    always_comb
    begin
        if (src2_is_4)
            imm = word_t'(`PC_STEP);
        else if (need_si20)
            imm = {i20, 12'b0};
        else if (need_ui5)
            imm = {27'b0, rk};
        else if (need_si12)
            imm = {{20{i12[11]}}, i12};
        else if (need_ui12)
            imm = {20'b0, i12};
        else
            imm = '0;
    end

    assign ctrl.alu_op[0]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                           | inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.alu_op[1]  = inst_sub_w;
    assign ctrl.alu_op[2]  = inst_slt | inst_slti;
    assign ctrl.alu_op[3]  = inst_sltu | inst_sltiu;
    assign ctrl.alu_op[4]  = inst_and | inst_andi;
    assign ctrl.alu_op[5]  = inst_nor;
    assign ctrl.alu_op[6]  = inst_or | inst_ori;
    assign ctrl.alu_op[7]  = inst_xor | inst_xori;
    assign ctrl.alu_op[8]  = inst_sll_w | inst_slli_w;
    assign ctrl.alu_op[9]  = inst_srl_w | inst_srli_w;
    assign ctrl.alu_op[10] = inst_sra_w | inst_srai_w;
    assign ctrl.alu_op[11] = inst_lu12i_w;

    assign ctrl.imm          = imm;
    assign ctrl.dest         = inst_bl ? reg_idx_t'(`LINK_REG) : rd;
    assign ctrl.gr_we        = alu_rr | alu_ri | need_si20 | inst_ld_w | inst_jirl | inst_bl;
    assign ctrl.mem_we       = inst_st_w;
    assign ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.src2_is_imm  = alu_ri | need_si20 | inst_ld_w | inst_st_w | src2_is_4;
    assign ctrl.res_from_mem = inst_ld_w;

    // stores and conditional branches take rd as the second source
    assign ctrl.raddr1    = rj;
    assign ctrl.raddr2    = (inst_st_w | cond_br) ? rd : rk;
    assign ctrl.reads_rj  = alu_rr | alu_ri | inst_ld_w | inst_st_w | inst_jirl | cond_br;
    assign ctrl.reads_rkd = alu_rr | inst_st_w | cond_br;

    assign ctrl.br_kind.beq      = inst_beq;
    assign ctrl.br_kind.bne      = inst_bne;
    assign ctrl.br_kind.blt      = inst_blt;
    assign ctrl.br_kind.bge      = inst_bge;
    assign ctrl.br_kind.bltu     = inst_bltu;
    assign ctrl.br_kind.bgeu     = inst_bgeu;
    assign ctrl.br_kind.jump_rel = inst_b | inst_bl;
    assign ctrl.br_kind.jirl     = inst_jirl;
    assign ctrl.offs             = {inst[9:0], inst[25:10]};

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module reg_file (
    input  logic                clk,
    input  isa_pkg::reg_idx_t   raddr1,
    input  isa_pkg::reg_idx_t   raddr2,
    input  pipe_pkg::reg_write_t wr,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2
);
    import isa_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (wr.we)
            regs[wr.dest] <= wr.data;
    end

    // r0 is hard-wired to zero whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hw/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  pipe_pkg::decode_ctrl_t ctrl,
    input  isa_pkg::word_t         rf_data1,
    input  isa_pkg::word_t         rf_data2,
    input  pipe_pkg::exec_bypass_t exec_bypass,
    input  pipe_pkg::reg_write_t   mem_bypass,
    input  pipe_pkg::reg_write_t   wb_write,
    output isa_pkg::word_t         rj_value,
    output isa_pkg::word_t         rkd_value,
    output logic                   stall
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic ex_hit1, ex_hit2;
    logic mem_hit1, mem_hit2;
    logic wb_hit1, wb_hit2;

    // a later stage supplies the operand only if it really writes that register
    function automatic logic src_hit(reg_write_t src, reg_idx_t idx, logic used);
        return src.we && (src.dest != '0) && used && (src.dest == idx);
    endfunction

    assign ex_hit1  = src_hit(exec_bypass.wr, ctrl.raddr1, ctrl.reads_rj);
    assign ex_hit2  = src_hit(exec_bypass.wr, ctrl.raddr2, ctrl.reads_rkd);
    assign mem_hit1 = src_hit(mem_bypass, ctrl.raddr1, ctrl.reads_rj);
    assign mem_hit2 = src_hit(mem_bypass, ctrl.raddr2, ctrl.reads_rkd);
    assign wb_hit1  = src_hit(wb_write, ctrl.raddr1, ctrl.reads_rj);
    assign wb_hit2  = src_hit(wb_write, ctrl.raddr2, ctrl.reads_rkd);

    // youngest producer first
    assign rj_value  = ex_hit1  ? exec_bypass.wr.data :
                       mem_hit1 ? mem_bypass.data     :
                       wb_hit1  ? wb_write.data       : rf_data1;
    assign rkd_value = ex_hit2  ? exec_bypass.wr.data :
                       mem_hit2 ? mem_bypass.data     :
                       wb_hit2  ? wb_write.data       : rf_data2;

    // load data is not ready until the memory stage
    assign stall = exec_bypass.is_load && (ex_hit1 || ex_hit2);

endmodule

// File: hw/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  pipe_pkg::decode_ctrl_t ctrl,
    input  isa_pkg::word_t         pc,
    input  isa_pkg::word_t         rj_value,
    input  isa_pkg::word_t         rkd_value,
    output logic                   branch_cond,
    output isa_pkg::word_t         target
);
    import isa_pkg::*;

    logic  rj_eq_rkd;
    logic  lt_signed;
    logic  lt_unsigned;
    word_t offs16_ext;
    word_t offs26_ext;

    assign rj_eq_rkd   = (rj_value == rkd_value);
    assign lt_signed   = ($signed(rj_value) < $signed(rkd_value));
    assign lt_unsigned = (rj_value < rkd_value);

    // offsets are in words
    assign offs16_ext = {{14{ctrl.offs[15]}}, ctrl.offs[15:0], 2'b00};
    assign offs26_ext = {{4{ctrl.offs[25]}}, ctrl.offs, 2'b00};

    assign branch_cond = (ctrl.br_kind.beq  &&  rj_eq_rkd)
                      || (ctrl.br_kind.bne  && !rj_eq_rkd)
                      || (ctrl.br_kind.blt  &&  lt_signed)
                      || (ctrl.br_kind.bge  && !lt_signed)
                      || (ctrl.br_kind.bltu &&  lt_unsigned)
                      || (ctrl.br_kind.bgeu && !lt_unsigned)
                      ||  ctrl.br_kind.jump_rel
                      ||  ctrl.br_kind.jirl;

    // jirl is register relative, everything else pc relative
    always_comb
    begin
        if (ctrl.br_kind.jirl)
            target = rj_value + offs16_ext;
        else if (ctrl.br_kind.jump_rel)
            target = pc + offs26_ext;
        else
            target = pc + offs16_ext;
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_valid,
    input  pipe_pkg::fetch_packet_t  fetch_packet,
    output logic                     decode_ready,
    output logic                     decode_valid,
    output pipe_pkg::decode_packet_t decode_packet,
    input  logic                     exec_ready,
    input  pipe_pkg::exec_bypass_t   exec_bypass,
    input  pipe_pkg::reg_write_t     mem_bypass,
    input  pipe_pkg::reg_write_t     wb_write,
    output pipe_pkg::branch_t        branch
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_packet_t held;
    logic          held_valid;
    decode_ctrl_t  ctrl;
    word_t         rf_data1;
    word_t         rf_data2;
    word_t         rj_value;
    word_t         rkd_value;
    word_t         target;
    logic          stall;
    logic          branch_cond;

    assign decode_ready = !held_valid || (!stall && exec_ready);
    assign decode_valid = held_valid && !stall;

    // a taken branch squashes whatever fetch offers on the same edge
    always_ff @(posedge clk)
    begin
        if (reset)
            held_valid <= 1'b0;
        else if (branch.taken && exec_ready)
            held_valid <= 1'b0;
        else if (decode_ready)
            held_valid <= fetch_valid;
    end

    always_ff @(posedge clk)
    begin
        if (fetch_valid && decode_ready)
            held <= fetch_packet;
    end

    inst_decoder u_decoder (
        .inst (held.inst),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .wr     (wb_write),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2)
    );

    operand_bypass u_bypass (
        .ctrl        (ctrl),
        .rf_data1    (rf_data1),
        .rf_data2    (rf_data2),
        .exec_bypass (exec_bypass),
        .mem_bypass  (mem_bypass),
        .wb_write    (wb_write),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .stall       (stall)
    );

    branch_resolver u_branch (
        .ctrl        (ctrl),
        .pc          (held.pc),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .branch_cond (branch_cond),
        .target      (target)
    );

    // no redirect while the operands are still waiting on a load
    assign branch.taken  = held_valid && !stall && branch_cond;
    assign branch.target = target;

    assign decode_packet.pc           = held.pc;
    assign decode_packet.rj_value     = rj_value;
    assign decode_packet.rkd_value    = rkd_value;
    assign decode_packet.imm          = ctrl.imm;
    assign decode_packet.dest         = ctrl.dest;
    assign decode_packet.gr_we        = ctrl.gr_we;
    assign decode_packet.mem_we       = ctrl.mem_we;
    assign decode_packet.alu_op       = ctrl.alu_op;
    assign decode_packet.src1_is_pc   = ctrl.src1_is_pc;
    assign decode_packet.src2_is_imm  = ctrl.src2_is_imm;
    assign decode_packet.res_from_mem = ctrl.res_from_mem;

endmodule

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    // about 800 cycles of stimulus with a wide margin
    localparam int CYCLE_LIMIT = 3000;

    logic           clk;
    logic           reset;
    logic           fetch_valid;
    fetch_packet_t  fetch_packet;
    logic           exec_ready;
    exec_bypass_t   exec_bypass;
    reg_write_t     mem_bypass;
    reg_write_t     wb_write;
    logic           decode_ready;
    logic           decode_valid;
    decode_packet_t decode_packet;
    branch_t        branch;

    word_t       shadow [`NUM_REGS];
    logic [31:0] lfsr_state;
    int          cycles;

    // instruction kinds
    //  0..10  add.w sub.w slt sltu and or xor nor sll.w srl.w sra.w
    // 11..19  slli.w srli.w srai.w addi.w slti sltiu andi ori xori
    // 20..23  lu12i.w pcaddu12i ld.w st.w
    // 24..32  jirl b bl beq bne blt bge bltu bgeu
    int          cur_kind;
    reg_idx_t    cur_rd;
    reg_idx_t    cur_rj;
    reg_idx_t    cur_rk;
    logic [25:0] cur_field;
    word_t       cur_pc;
    word_t       exp_rj;
    word_t       exp_rkd;
    word_t       exp_target;
    logic        exp_taken;

    decode_stage u_dut (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_packet  (fetch_packet),
        .decode_ready  (decode_ready),
        .decode_valid  (decode_valid),
        .decode_packet (decode_packet),
        .exec_ready    (exec_ready),
        .exec_bypass   (exec_bypass),
        .mem_bypass    (mem_bypass),
        .wb_write      (wb_write),
        .branch        (branch)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // architectural view of the register file
    always @(posedge clk)
    begin
        if (wb_write.we && wb_write.dest != '0)
            shadow[wb_write.dest] <= wb_write.data;
    end

    task fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first failed check");
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic inst_t encode(input int k, input reg_idx_t rd, input reg_idx_t rj,
                                     input reg_idx_t rk, input logic [25:0] f);
        case (k)
            0:  return {`OP_ADD_W, rk, rj, rd};
            1:  return {`OP_SUB_W, rk, rj, rd};
            2:  return {`OP_SLT, rk, rj, rd};
            3:  return {`OP_SLTU, rk, rj, rd};
            4:  return {`OP_AND, rk, rj, rd};
            5:  return {`OP_OR, rk, rj, rd};
            6:  return {`OP_XOR, rk, rj, rd};
            7:  return {`OP_NOR, rk, rj, rd};
            8:  return {`OP_SLL_W, rk, rj, rd};
            9:  return {`OP_SRL_W, rk, rj, rd};
            10: return {`OP_SRA_W, rk, rj, rd};
            11: return {`OP_SLLI_W, rk, rj, rd};
            12: return {`OP_SRLI_W, rk, rj, rd};
            13: return {`OP_SRAI_W, rk, rj, rd};
            14: return {`OP_ADDI_W, f[11:0], rj, rd};
            15: return {`OP_SLTI, f[11:0], rj, rd};
            16: return {`OP_SLTIU, f[11:0], rj, rd};
            17: return {`OP_ANDI, f[11:0], rj, rd};
            18: return {`OP_ORI, f[11:0], rj, rd};
            19: return {`OP_XORI, f[11:0], rj, rd};
            20: return {`OP_LU12I_W, f[19:0], rd};
            21: return {`OP_PCADDU12I, f[19:0], rd};
            22: return {`OP_LD_W, f[11:0], rj, rd};
            23: return {`OP_ST_W, f[11:0], rj, rd};
            24: return {`OP_JIRL, f[15:0], rj, rd};
            // offs26 is split with the low half first
            25: return {`OP_B, f[15:0], f[25:16]};
            26: return {`OP_BL, f[15:0], f[25:16]};
            27: return {`OP_BEQ, f[15:0], rj, rd};
            28: return {`OP_BNE, f[15:0], rj, rd};
            29: return {`OP_BLT, f[15:0], rj, rd};
            30: return {`OP_BGE, f[15:0], rj, rd};
            31: return {`OP_BLTU, f[15:0], rj, rd};
            32: return {`OP_BGEU, f[15:0], rj, rd};
            default: return '0;
        endcase
    endfunction

    function automatic logic reads_rj(input int k);
        return !(k == 20 || k == 21 || k == 25 || k == 26);
    endfunction

    function automatic logic reads_rkd(input int k);
        return k <= 10 || k == 23 || k >= 27;
    endfunction

    // stores and conditional branches read rd
    function automatic reg_idx_t second_src();
        return (cur_kind == 23 || cur_kind >= 27) ? cur_rd : cur_rk;
    endfunction

    function automatic alu_op_t expect_alu(input int k);
        alu_op_t a;
        a = '0;
        case (k)
            0, 14, 21, 22, 23, 24, 26: a[0] = 1'b1;
            1:      a[1] = 1'b1;
            2, 15:  a[2] = 1'b1;
            3, 16:  a[3] = 1'b1;
            4, 17:  a[4] = 1'b1;
            7:      a[5] = 1'b1;
            5, 18:  a[6] = 1'b1;
            6, 19:  a[7] = 1'b1;
            8, 11:  a[8] = 1'b1;
            9, 12:  a[9] = 1'b1;
            10, 13: a[10] = 1'b1;
            20:     a[11] = 1'b1;
            default: a = '0;
        endcase
        return a;
    endfunction

    function automatic word_t expect_imm(input int k);
        if (k == 24 || k == 26)
            return `PC_STEP;
        if (k == 20 || k == 21)
            return {cur_field[19:0], 12'b0};
        if (k >= 11 && k <= 13)
            return {27'b0, cur_rk};
        if ((k >= 14 && k <= 16) || k == 22 || k == 23)
            return {{20{cur_field[11]}}, cur_field[11:0]};
        if (k >= 17 && k <= 19)
            return {20'b0, cur_field[11:0]};
        return '0;
    endfunction

    // youngest writer wins and r0 never comes from a bypass
    function automatic word_t expect_operand(input reg_idx_t idx, input logic used);
        if (used && exec_bypass.wr.we && exec_bypass.wr.dest != '0 && exec_bypass.wr.dest == idx)
            return exec_bypass.wr.data;
        if (used && mem_bypass.we && mem_bypass.dest != '0 && mem_bypass.dest == idx)
            return mem_bypass.data;
        if (used && wb_write.we && wb_write.dest != '0 && wb_write.dest == idx)
            return wb_write.data;
        return shadow[idx];
    endfunction

    function automatic reg_write_t random_write();
        reg_write_t w;
        w.we   = rand_bits(1);
        w.dest = reg_idx_t'(rand_bits(2));
        w.data = rand_bits(32);
        return w;
    endfunction

    task pick_inst(input int k, input int idx_bits);
        cur_kind  = k;
        cur_rd    = reg_idx_t'(rand_bits(idx_bits));
        cur_rj    = reg_idx_t'(rand_bits(idx_bits));
        cur_rk    = reg_idx_t'(rand_bits(idx_bits));
        cur_field = rand_bits(26);
        cur_pc    = rand_bits(30) << 2;
        // equal operands now and then so that beq and bge see both outcomes
        if (rand_bits(2) == 0)
            cur_rd = cur_rj;
    endtask

    task predict();
        logic lt_s;
        logic lt_u;
        exp_rj  = expect_operand(cur_rj, reads_rj(cur_kind));
        exp_rkd = expect_operand(second_src(), reads_rkd(cur_kind));
        lt_s    = $signed(exp_rj) < $signed(exp_rkd);
        lt_u    = exp_rj < exp_rkd;
        case (cur_kind)
            24, 25, 26: exp_taken = 1'b1;
            27: exp_taken = (exp_rj == exp_rkd);
            28: exp_taken = (exp_rj != exp_rkd);
            29: exp_taken = lt_s;
            30: exp_taken = !lt_s;
            31: exp_taken = lt_u;
            32: exp_taken = !lt_u;
            default: exp_taken = 1'b0;
        endcase
        if (cur_kind == 24)
            exp_target = exp_rj + {{14{cur_field[15]}}, cur_field[15:0], 2'b00};
        else if (cur_kind == 25 || cur_kind == 26)
            exp_target = cur_pc + {{4{cur_field[25]}}, cur_field, 2'b00};
        else
            exp_target = cur_pc + {{14{cur_field[15]}}, cur_field[15:0], 2'b00};
    endtask

    task check_decode();
        logic [4:0] flags;
        logic [4:0] exp_flags;
        int         k;
        k = cur_kind;
        flags = {decode_packet.gr_we, decode_packet.mem_we, decode_packet.src1_is_pc,
                 decode_packet.src2_is_imm, decode_packet.res_from_mem};
        exp_flags = {!(k == 23 || k == 25 || k >= 27), k == 23, k == 21 || k == 24 || k == 26,
                     (k >= 11 && k <= 24) || k == 26, k == 22};
        assert (decode_valid)
            else fail_check($sformatf("kind %0d: decode_valid low while held", k));
        assert (decode_packet.pc == cur_pc)
            else fail_check($sformatf("kind %0d: pc %h, expected %h", k, decode_packet.pc, cur_pc));
        assert (flags == exp_flags)
            else fail_check($sformatf("kind %0d: flags %b, expected %b", k, flags, exp_flags));
        assert (decode_packet.imm == expect_imm(k))
            else fail_check($sformatf("kind %0d: imm %h, expected %h", k,
                                      decode_packet.imm, expect_imm(k)));
        assert (k == 25 || k >= 27 || decode_packet.alu_op == expect_alu(k))
            else fail_check($sformatf("kind %0d: alu_op %b, expected %b", k,
                                      decode_packet.alu_op, expect_alu(k)));
        // bl links through the fixed register
        assert (!exp_flags[4] || decode_packet.dest == ((k == 26) ? `LINK_REG : cur_rd))
            else fail_check($sformatf("kind %0d: dest %0d", k, decode_packet.dest));
        assert (!reads_rj(k) || decode_packet.rj_value == exp_rj)
            else fail_check($sformatf("kind %0d: rj_value %h, expected %h", k,
                                      decode_packet.rj_value, exp_rj));
        assert (!reads_rkd(k) || decode_packet.rkd_value == exp_rkd)
            else fail_check($sformatf("kind %0d: rkd_value %h, expected %h", k,
                                      decode_packet.rkd_value, exp_rkd));
        assert (branch.taken == exp_taken)
            else fail_check($sformatf("kind %0d: branch.taken %b, expected %b", k,
                                      branch.taken, exp_taken));
        assert (!exp_taken || branch.target == exp_target)
            else fail_check($sformatf("kind %0d: target %h, expected %h", k,
                                      branch.target, exp_target));
    endtask

    // returns 2 ns after the edge that loaded the instruction
    task issue();
        logic accepted;
        @(posedge clk);
        #2;
        fetch_valid       = 1'b1;
        fetch_packet.inst = encode(cur_kind, cur_rd, cur_rj, cur_rk, cur_field);
        fetch_packet.pc   = cur_pc;
        accepted          = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = decode_ready;
            @(posedge clk);
            #2;
        end
        fetch_valid = 1'b0;
    endtask

    // check the held instruction, let it go and make sure it leaves once
    task finish_inst();
        predict();
        // fetch offers a follower that the taken branch has to squash
        if (exp_taken)
        begin
            fetch_valid       = 1'b1;
            fetch_packet.inst = encode(0, cur_rd, cur_rj, cur_rk, cur_field);
            fetch_packet.pc   = cur_pc + 4;
        end
        @(negedge clk);
        check_decode();
        @(posedge clk);
        #2;
        fetch_valid = 1'b0;
        exec_bypass = '0;
        mem_bypass  = '0;
        wb_write    = '0;
        @(negedge clk);
        assert (!decode_valid)
            else fail_check("decode_valid still high after the transfer");
    endtask

    initial
    begin
        int             i;
        int             k;
        int             rep;
        int             hold;
        decode_packet_t saved;
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_packet = '0;
        exec_ready   = 1'b1;
        exec_bypass  = '0;
        mem_bypass   = '0;
        wb_write     = '0;
        cycles       = 0;
        lfsr_state   = 32'h74dd5b4a;
        for (i = 0; i < `NUM_REGS; i++)
            shadow[i] <= '0;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!decode_valid && !branch.taken)
            else fail_check("decode_valid or branch.taken high after reset");

        // r0 is written too and must still read zero
        for (i = 0; i < `NUM_REGS; i++)
        begin
            @(posedge clk);
            #2;
            wb_write.we   = 1'b1;
            wb_write.dest = reg_idx_t'(i);
            wb_write.data = rand_bits(32);
        end
        @(posedge clk);
        #2;
        wb_write = '0;

        // every kind with operands straight from the register file
        for (k = 0; k < 33; k++)
        begin
            for (rep = 0; rep < 4; rep++)
            begin
                pick_inst(k, 5);
                issue();
                finish_inst();
            end
        end

        // overlapping producers on r0..r3
        for (rep = 0; rep < 40; rep++)
        begin
            pick_inst(rand_bits(8) % 33, 2);
            issue();
            exec_bypass.wr      = random_write();
            exec_bypass.is_load = 1'b0;
            mem_bypass          = random_write();
            wb_write            = random_write();
            finish_inst();
        end

        // load in execute feeding an operand
        for (rep = 0; rep < 12; rep++)
        begin
            k = rand_bits(1) ? 27 + rand_bits(8) % 6 : rand_bits(8) % 11;
            pick_inst(k, 5);
            if (cur_rj == '0)
                cur_rj = 5'd1;
            if (cur_rd == '0)
                cur_rd = 5'd2;
            if (cur_rk == '0)
                cur_rk = 5'd3;
            issue();
            exec_bypass.wr.we   = 1'b1;
            exec_bypass.wr.dest = rand_bits(1) ? cur_rj : second_src();
            exec_bypass.wr.data = rand_bits(32);
            exec_bypass.is_load = 1'b1;
            hold = 1 + rand_bits(2);
            repeat (hold)
            begin
                @(negedge clk);
                assert (!decode_valid && !decode_ready && !branch.taken)
                    else fail_check("handshake or branch active during a load-use stall");
                @(posedge clk);
                #2;
            end
            exec_bypass = '0;
            finish_inst();
        end

        // execute holds off on non-branch kinds while fetch offers a follower
        for (rep = 0; rep < 12; rep++)
        begin
            pick_inst(rand_bits(8) % 24, 5);
            issue();
            exec_ready        = 1'b0;
            fetch_valid       = 1'b1;
            fetch_packet.inst = encode(0, cur_rj, cur_rd, cur_rk, cur_field);
            fetch_packet.pc   = cur_pc + 4;
            @(negedge clk);
            saved = decode_packet;
            hold  = 1 + rand_bits(2);
            repeat (hold)
            begin
                @(posedge clk);
                #2;
                @(negedge clk);
                assert (decode_valid && !decode_ready && decode_packet == saved)
                    else fail_check("packet changed or decode_ready high under back-pressure");
            end
            @(posedge clk);
            #2;
            fetch_valid = 1'b0;
            exec_ready  = 1'b1;
            finish_inst();
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_bypass.sv
hw/branch_resolver.sv
hw/decode_stage.sv
test/decode_stage_tb.sv
